//--- design/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Data path and CSR address widths
`define CSR_XLEN            32
`define CSR_ADDR_W          12

// User counters, read-only from every mode
`define CSR_ADDR_CYCLE      12'hc00
`define CSR_ADDR_TIME       12'hc01
`define CSR_ADDR_CYCLEH     12'hc80
`define CSR_ADDR_TIMEH      12'hc81

// Machine information and trap setup
`define CSR_ADDR_MVENDORID  12'hf11
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305

// Machine trap handling
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MIP        12'h344

// MXL=1 (RV32), extensions A, I and M
`define CSR_MISA_VALUE      32'h4000_1101

// Exception codes and the timer interrupt code with bit 31 set
`define CSR_CAUSE_ECALL_U   32'h0000_0008
`define CSR_CAUSE_ECALL_M   32'h0000_000b
`define CSR_CAUSE_MTIMER    32'h8000_0007

`endif

//--- design/csr_pkg.sv
`include "csr_cfg.svh"

package csr_pkg;

    // Command issued by decode for the CSR stage
    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Only machine and user mode exist here
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_e;

    // One request per cycle from the previous stage
    typedef struct packed {
        csr_cmd_e                cmd;
        logic [`CSR_ADDR_W-1:0]  addr;
        logic [`CSR_XLEN-1:0]    op1;
    } csr_req_t;

    // Result towards writeback and the fetch redirect
    typedef struct packed {
        csr_cmd_e                cmd;
        logic [`CSR_XLEN-1:0]    rdata;
        logic [`CSR_XLEN-1:0]    trap_vector;
    } csr_resp_t;

    // Decoded software write to registers owned by the trap controller
    typedef struct packed {
        logic                    we_mstatus;
        logic                    we_mepc;
        logic                    we_mcause;
        logic [`CSR_XLEN-1:0]    wdata;
    } csr_wr_t;

    // Trap controller state seen by the register file
    typedef struct packed {
        priv_e                   mode;
        logic                    mie;
        logic                    mpie;
        priv_e                   mpp;
        logic [`CSR_XLEN-1:0]    mepc;
        logic [`CSR_XLEN-1:0]    mcause;
    } trap_state_t;

endpackage

//--- design/csr_timer.sv
`timescale 1ns/1ns

module csr_timer (
    input  logic        clk,
    input  logic        rst,
    input  logic [63:0] mtime,
    input  logic [63:0] mtimecmp,
    output logic [63:0] cycle,
    output logic        mtip
);

    // Free running cycle count
    // wraps after 2^64 clocks, never in practice
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= 64'd0;
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

    // Machine timer pending
    // Level signal, stays high until software moves mtimecmp ahead of mtime
    // Unsigned compare over the full 64 bits
    assign mtip = (mtime >= mtimecmp);

endmodule

//--- design/csr_trap_ctrl.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_trap_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  csr_pkg::csr_req_t     req,
    input  logic                  flush,
    input  logic                  irq_ready,
    input  logic [`CSR_XLEN-1:0]  fetch_pc,
    input  csr_pkg::csr_wr_t      wr,
    input  logic [`CSR_XLEN-1:0]  mtvec,
    input  logic                  mtie,
    input  logic                  mtip,
    output csr_pkg::csr_cmd_e     req_cmd,
    output csr_pkg::trap_state_t  tstate,
    output csr_pkg::csr_cmd_e     resp_cmd,
    output logic [`CSR_XLEN-1:0]  trap_vector,
    output logic                  stall_may_irq
);
    import csr_pkg::*;

    logic                  irq_take;
    logic [`CSR_XLEN-1:0]  tvec_base;
    logic [`CSR_XLEN-1:0]  irq_vector;

    // Flushed slot behaves as a bubble for every block downstream
    assign req_cmd = flush ? CSR_NONE : req.cmd;

    // Earlier stages drain while the timer interrupt is armed
    assign stall_may_irq = tstate.mie && mtie;
    assign irq_take      = stall_may_irq && mtip && irq_ready;

    // mtvec mode 1 in bits 1:0 selects vectored
    assign tvec_base  = {mtvec[`CSR_XLEN-1:2], 2'b00};
    // Vectored offset is four times the interrupt code without bit 31
    assign irq_vector = (mtvec[1:0] == 2'b01) ?
                        tvec_base + ((`CSR_CAUSE_MTIMER & 32'h7fff_ffff) << 2) : tvec_base;

    always_ff @(posedge clk) begin
        if (rst) begin
            tstate.mode   <= PRIV_M;
            tstate.mie    <= 1'b0;
            tstate.mpie   <= 1'b0;
            tstate.mpp    <= PRIV_M;
            tstate.mepc   <= '0;
            tstate.mcause <= '0;
            resp_cmd      <= CSR_NONE;
            trap_vector   <= '0;
        end else begin
            // Write-back from the register file
            // any trap below in the same cycle overrides these
            if (wr.we_mstatus) begin
                tstate.mie  <= wr.wdata[3];
                tstate.mpie <= wr.wdata[7];
                // MPP is WARL so anything but M reads back as U
                tstate.mpp  <= (wr.wdata[12:11] == PRIV_M) ? PRIV_M : PRIV_U;
            end
            if (wr.we_mepc) begin
                tstate.mepc <= wr.wdata;
            end
            if (wr.we_mcause) begin
                tstate.mcause <= wr.wdata;
            end

            if (irq_take) begin
                // Reported to the pipeline as an ecall
                resp_cmd      <= CSR_ECALL;
                trap_vector   <= irq_vector;
                tstate.mode   <= PRIV_M;
                tstate.mcause <= `CSR_CAUSE_MTIMER;
                tstate.mepc   <= fetch_pc;
                tstate.mpp    <= tstate.mode;
                tstate.mpie   <= tstate.mie;
                tstate.mie    <= 1'b0;
            end else begin
                resp_cmd <= req_cmd;
                case (req_cmd)
                    CSR_ECALL: begin
                        // Synchronous exceptions are never vectored
                        trap_vector   <= tvec_base;
                        tstate.mcause <= (tstate.mode == PRIV_U) ?
                                         `CSR_CAUSE_ECALL_U : `CSR_CAUSE_ECALL_M;
                        tstate.mode   <= PRIV_M;
                    end
                    CSR_MRET: begin
                        trap_vector <= tstate.mepc;
                        tstate.mode <= tstate.mpp;
                        tstate.mie  <= tstate.mpie;
                        tstate.mpp  <= PRIV_U;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

//--- design/csr_regfile.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  csr_pkg::csr_req_t     req,
    input  csr_pkg::csr_cmd_e     req_cmd,
    input  csr_pkg::trap_state_t  tstate,
    input  logic [63:0]           cycle,
    input  logic [63:0]           mtime,
    input  logic                  mtip,
    output logic [`CSR_XLEN-1:0]  rdata,
    output csr_pkg::csr_wr_t      wr,
    output logic [`CSR_XLEN-1:0]  mtvec,
    output logic                  mtie
);
    import csr_pkg::*;

    logic                    is_csr_op;
    logic                    can_access;
    logic                    can_write;
    logic [`CSR_XLEN-1:0]    rd_val;
    logic [`CSR_XLEN-1:0]    mscratch;
    csr_cmd_e                save_cmd;
    logic                    save_we;
    logic [`CSR_ADDR_W-1:0]  save_addr;
    logic [`CSR_XLEN-1:0]    save_op1;
    logic [`CSR_XLEN-1:0]    wdata;

    assign is_csr_op = (req_cmd == CSR_W) || (req_cmd == CSR_S) || (req_cmd == CSR_C);

    // Bits 9:8 give the lowest privilege allowed
    assign can_access = (req.addr[9:8] <= tstate.mode);
    // 11:10 == 2'b11 marks a read-only CSR
    assign can_write  = can_access && (req.addr[11:10] != 2'b11);

    // Read mux, unimplemented addresses give zero
    always_comb begin
        case (req.addr)
            `CSR_ADDR_CYCLE:     rd_val = cycle[31:0];
            `CSR_ADDR_TIME:      rd_val = mtime[31:0];
            `CSR_ADDR_CYCLEH:    rd_val = cycle[63:32];
            `CSR_ADDR_TIMEH:     rd_val = mtime[63:32];
            `CSR_ADDR_MVENDORID: rd_val = '0;
            `CSR_ADDR_MISA:      rd_val = `CSR_MISA_VALUE;
            // MPP at 12:11, MPIE at 7, MIE at 3
            `CSR_ADDR_MSTATUS:   rd_val = {19'd0, tstate.mpp, 3'd0, tstate.mpie,
                                           3'd0, tstate.mie, 3'd0};
            `CSR_ADDR_MIE:       rd_val = {24'd0, mtie, 7'd0};
            `CSR_ADDR_MTVEC:     rd_val = mtvec;
            `CSR_ADDR_MSCRATCH:  rd_val = mscratch;
            `CSR_ADDR_MEPC:      rd_val = tstate.mepc;
            `CSR_ADDR_MCAUSE:    rd_val = tstate.mcause;
            `CSR_ADDR_MIP:       rd_val = {24'd0, mtip, 7'd0};
            default:             rd_val = '0;
        endcase
    end

    // First stage, old value out and request held
    always_ff @(posedge clk) begin
        if (rst) begin
            rdata    <= '0;
            save_cmd <= CSR_NONE;
            save_we  <= 1'b0;
        end else begin
            rdata    <= (is_csr_op && can_access) ? rd_val : '0;
            save_cmd <= req_cmd;
            save_we  <= is_csr_op && can_write;
        end
    end

    always_ff @(posedge clk) begin
        save_addr <= req.addr;
        save_op1  <= req.op1;
    end

    // New value built from the registered old value
    always_comb begin
        case (save_cmd)
            CSR_W:   wdata = save_op1;
            CSR_S:   wdata = rdata | save_op1;
            CSR_C:   wdata = rdata & ~save_op1;
            default: wdata = rdata;
        endcase
    end

    // Second stage, write-back of locally stored CSRs
    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= '0;
            mtvec    <= '0;
            mtie     <= 1'b0;
        end else if (save_we) begin
            case (save_addr)
                `CSR_ADDR_MSCRATCH: mscratch <= wdata;
                `CSR_ADDR_MTVEC:    mtvec    <= wdata;
                `CSR_ADDR_MIE:      mtie     <= wdata[7];
                default: begin
                end
            endcase
        end
    end

    // Trap-owned CSRs go out as enables
    assign wr.we_mstatus = save_we && (save_addr == `CSR_ADDR_MSTATUS);
    assign wr.we_mepc    = save_we && (save_addr == `CSR_ADDR_MEPC);
    assign wr.we_mcause  = save_we && (save_addr == `CSR_ADDR_MCAUSE);
    // mepc is word aligned
    assign wr.wdata      = (save_addr == `CSR_ADDR_MEPC) ?
                           {wdata[`CSR_XLEN-1:2], 2'b00} : wdata;

endmodule

//--- design/csr_unit.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  csr_pkg::csr_req_t     req,
    input  logic                  flush,
    input  logic                  irq_ready,
    input  logic [`CSR_XLEN-1:0]  fetch_pc,
    input  logic [63:0]           mtime,
    input  logic [63:0]           mtimecmp,
    output csr_pkg::csr_resp_t    resp,
    output logic                  stall_may_irq
);
    import csr_pkg::*;

    csr_cmd_e              req_cmd;
    csr_cmd_e              resp_cmd;
    csr_wr_t               wr;
    trap_state_t           tstate;
    logic [`CSR_XLEN-1:0]  mtvec;
    logic [`CSR_XLEN-1:0]  rdata;
    logic [`CSR_XLEN-1:0]  trap_vector;
    logic                  mtie;
    logic [63:0]           cycle;
    logic                  mtip;

    // Counters and timer compare
    csr_timer u_csr_timer (
        .clk      (clk),
        .rst      (rst),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .cycle    (cycle),
        .mtip     (mtip)
    );

    // CSR storage, read path and write-back
    csr_regfile u_csr_regfile (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .req_cmd (req_cmd),
        .tstate  (tstate),
        .cycle   (cycle),
        .mtime   (mtime),
        .mtip    (mtip),
        .rdata   (rdata),
        .wr      (wr),
        .mtvec   (mtvec),
        .mtie    (mtie)
    );

    // Privilege mode, traps and mret
    csr_trap_ctrl u_csr_trap_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .flush         (flush),
        .irq_ready     (irq_ready),
        .fetch_pc      (fetch_pc),
        .wr            (wr),
        .mtvec         (mtvec),
        .mtie          (mtie),
        .mtip          (mtip),
        .req_cmd       (req_cmd),
        .tstate        (tstate),
        .resp_cmd      (resp_cmd),
        .trap_vector   (trap_vector),
        .stall_may_irq (stall_may_irq)
    );

    // All three fields are already registered
    assign resp.cmd         = resp_cmd;
    assign resp.rdata       = rdata;
    assign resp.trap_vector = trap_vector;

endmodule

//--- verif/csr_unit_props.sv
`timescale 1ns/1ns

module csr_unit_props (
    input  logic                  clk,
    input  logic                  rst,
    input  csr_pkg::csr_req_t     req,
    input  csr_pkg::csr_cmd_e     req_cmd,
    input  csr_pkg::trap_state_t  tstate,
    input  logic                  mtip,
    input  logic                  irq_ready,
    input  csr_pkg::csr_resp_t    resp,
    input  logic                  stall_may_irq
);
    import csr_pkg::*;

    // Number of assertion failures
    int fail_count = 0;

    // Outputs idle one cycle after any reset cycle
    reset_state: assert property (@(posedge clk) rst |=> (resp == '0) && !stall_may_irq)
        else begin
            $error("Outputs not at their reset values after reset");
            fail_count++;
        end

    // Armed timer with a pending compare and an idle pipeline traps at once
    irq_taken_when_armed: assert property (@(posedge clk) disable iff (rst)
        stall_may_irq && mtip && irq_ready |=>
        (resp.cmd == CSR_ECALL) && (tstate.mode == PRIV_M) && !tstate.mie)
        else begin
            $error("Armed timer interrupt was not taken");
            fail_count++;
        end

    // Without the enables only an ecall request gives an ECALL response
    no_irq_when_disarmed: assert property (@(posedge clk) disable iff (rst)
        !stall_may_irq && (req_cmd != CSR_ECALL) |=> (resp.cmd != CSR_ECALL))
        else begin
            $error("Interrupt taken while stall_may_irq was low");
            fail_count++;
        end

    // Machine CSRs are invisible from user mode
    user_access_blocked: assert property (@(posedge clk) disable iff (rst)
        (req_cmd inside {CSR_W, CSR_S, CSR_C}) && (tstate.mode == PRIV_U) &&
        (req.addr[9:8] != 2'b00) |=> (resp.rdata == '0))
        else begin
            $error("User-mode access to a machine CSR returned data");
            fail_count++;
        end

endmodule

bind csr_unit csr_unit_props u_csr_unit_props (
    .clk           (clk),
    .rst           (rst),
    .req           (req),
    .req_cmd       (req_cmd),
    .tstate        (tstate),
    .mtip          (mtip),
    .irq_ready     (irq_ready),
    .resp          (resp),
    .stall_may_irq (stall_may_irq)
);

//--- verif/csr_unit_tb.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_unit_tb;
    import csr_pkg::*;

    logic         clk;
    logic         rst;
    csr_req_t     req;
    logic         flush;
    logic         irq_ready;
    logic [31:0]  fetch_pc;
    logic [63:0]  mtime;
    logic [63:0]  mtimecmp;
    csr_resp_t    resp;
    logic         stall_may_irq;

    // Reference model of the architectural state
    logic [31:0]  m_mscratch;
    logic [31:0]  m_mtvec;
    logic         m_mtie;
    logic [31:0]  m_mepc;
    logic [31:0]  m_mcause;
    logic [1:0]   m_mode;
    logic         m_mie;
    logic         m_mpie;
    logic [1:0]   m_mpp;

    int           errors = 0;
    int           timeouts = 0;
    logic [31:0]  lcg_state = 32'h980;

    csr_unit u_csr_unit (
        .clk           (clk),
        .rst           (rst),
        .req           (req),
        .flush         (flush),
        .irq_ready     (irq_ready),
        .fetch_pc      (fetch_pc),
        .mtime         (mtime),
        .mtimecmp      (mtimecmp),
        .resp          (resp),
        .stall_may_irq (stall_may_irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Architectural view of a CSR, counters excluded
    function automatic logic [31:0] read_expected(logic [11:0] addr);
        case (addr)
            `CSR_ADDR_TIME:     return mtime[31:0];
            `CSR_ADDR_TIMEH:    return mtime[63:32];
            `CSR_ADDR_MISA:     return `CSR_MISA_VALUE;
            `CSR_ADDR_MSTATUS:  return (32'(m_mpp) << 11) | (32'(m_mpie) << 7) | (32'(m_mie) << 3);
            `CSR_ADDR_MIE:      return 32'(m_mtie) << 7;
            `CSR_ADDR_MIP:      return (mtime >= mtimecmp) ? 32'h80 : 32'h0;
            `CSR_ADDR_MTVEC:    return m_mtvec;
            `CSR_ADDR_MSCRATCH: return m_mscratch;
            `CSR_ADDR_MEPC:     return m_mepc;
            `CSR_ADDR_MCAUSE:   return m_mcause;
            default:            return 32'h0;
        endcase
    endfunction

    function automatic void apply_write(logic [11:0] addr, logic [31:0] v);
        case (addr)
            `CSR_ADDR_MSCRATCH: m_mscratch = v;
            `CSR_ADDR_MTVEC:    m_mtvec = v;
            `CSR_ADDR_MIE:      m_mtie = v[7];
            `CSR_ADDR_MEPC:     m_mepc = v & ~32'h3;
            `CSR_ADDR_MCAUSE:   m_mcause = v;
            `CSR_ADDR_MSTATUS: begin
                m_mie  = v[3];
                m_mpie = v[7];
                // Only M survives in MPP, the rest becomes U
                m_mpp  = (v[12:11] == 2'b11) ? 2'b11 : 2'b00;
            end
            default: begin
            end
        endcase
    endfunction

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            errors++;
        end
    endtask

    // One request slot, result sampled at the following falling edge
    task automatic send(csr_cmd_e cmd, logic [11:0] addr, logic [31:0] op1, logic fl,
                        output csr_resp_t got);
        @(posedge clk);
        req   <= '{cmd: cmd, addr: addr, op1: op1};
        flush <= fl;
        @(posedge clk);
        req   <= '{cmd: CSR_NONE, addr: 12'h0, op1: 32'h0};
        flush <= 1'b0;
        @(negedge clk);
        got = resp;
    endtask

    task automatic set_timer(logic [63:0] t, logic [63:0] cmp);
        @(posedge clk);
        mtime    <= t;
        mtimecmp <= cmp;
        @(negedge clk);
    endtask

    // W, S or C with old value check, then the model takes the new value
    task automatic csr_op(csr_cmd_e cmd, logic [11:0] addr, logic [31:0] op1);
        logic [31:0]  old;
        logic [31:0]  nv;
        logic         ok;
        csr_resp_t    got;
        ok  = (addr[9:8] <= m_mode);
        old = ok ? read_expected(addr) : 32'h0;
        send(cmd, addr, op1, 1'b0, got);
        check_value("resp.cmd", 32'(cmd), 32'(got.cmd));
        check_value("resp.rdata", old, got.rdata);
        case (cmd)
            CSR_W:   nv = op1;
            CSR_S:   nv = old | op1;
            default: nv = old & ~op1;
        endcase
        // Top address bits 11 mark read-only space
        if (ok && (addr[11:10] != 2'b11)) begin
            apply_write(addr, nv);
        end
    endtask

    task automatic trap_op(csr_cmd_e cmd);
        logic [31:0]  tv;
        csr_resp_t    got;
        // Ecall ignores vectored mode
        tv = (cmd == CSR_ECALL) ? (m_mtvec & ~32'h3) : m_mepc;
        send(cmd, 12'h0, 32'h0, 1'b0, got);
        check_value("resp.cmd", 32'(cmd), 32'(got.cmd));
        check_value("resp.rdata", 32'h0, got.rdata);
        check_value("resp.trap_vector", tv, got.trap_vector);
        if (cmd == CSR_ECALL) begin
            m_mcause = (m_mode == 2'b00) ? `CSR_CAUSE_ECALL_U : `CSR_CAUSE_ECALL_M;
            m_mode   = 2'b11;
        end else begin
            m_mode = m_mpp;
            m_mie  = m_mpie;
            m_mpp  = 2'b00;
        end
    endtask

    initial begin
        logic [31:0]  r;
        logic [31:0]  c0;
        logic [31:0]  base;
        logic [31:0]  pc;
        csr_cmd_e     cmd;
        logic [11:0]  addr;
        csr_resp_t    got;
        int           k;
        int           n;
        rst       = 1'b1;
        req       = '0;
        flush     = 1'b0;
        irq_ready = 1'b0;
        fetch_pc  = 32'h0;
        mtime     = 64'h0;
        mtimecmp  = '1;
        m_mscratch = 32'h0;
        m_mtvec    = 32'h0;
        m_mtie     = 1'b0;
        m_mepc     = 32'h0;
        m_mcause   = 32'h0;
        m_mode     = 2'b11;
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_mpp      = 2'b11;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("resp.cmd", 32'(CSR_NONE), 32'(resp.cmd));
        check_value("stall_may_irq", 32'h0, 32'(stall_may_irq));

        // Random W/S/C on the two plain machine registers
        for (int i = 0; i < 16; i++) begin
            r    = next_rand();
            cmd  = csr_cmd_e'(3'd1 + 3'(r % 3));
            addr = r[8] ? `CSR_ADDR_MSCRATCH : `CSR_ADDR_MTVEC;
            csr_op(cmd, addr, next_rand());
        end

        // Read-only space and unimplemented address
        csr_op(CSR_W, `CSR_ADDR_MISA, next_rand());
        csr_op(CSR_S, `CSR_ADDR_MISA, 32'h0);
        csr_op(CSR_W, `CSR_ADDR_MVENDORID, next_rand());
        csr_op(CSR_S, `CSR_ADDR_MVENDORID, 32'h0);
        csr_op(CSR_S, 12'h7c0, next_rand());
        set_timer({next_rand(), next_rand()}, '1);
        csr_op(CSR_S, `CSR_ADDR_TIME, 32'h0);
        csr_op(CSR_S, `CSR_ADDR_TIMEH, 32'h0);

        // Cycle reads k idle cycles apart, plus the two cycles of one slot
        send(CSR_S, `CSR_ADDR_CYCLE, 32'h0, 1'b0, got);
        c0 = got.rdata;
        k  = 1 + int'(next_rand() % 6);
        repeat (k) @(posedge clk);
        send(CSR_S, `CSR_ADDR_CYCLE, 32'h0, 1'b0, got);
        check_value("cycle delta", 32'(k + 2), got.rdata - c0);

        // Machine ecall and mret
        csr_op(CSR_W, `CSR_ADDR_MTVEC, (next_rand() & ~32'h3) | 32'h1);
        csr_op(CSR_W, `CSR_ADDR_MEPC, next_rand());
        trap_op(CSR_ECALL);
        csr_op(CSR_S, `CSR_ADDR_MCAUSE, 32'h0);
        trap_op(CSR_MRET);

        // Drop to user mode, machine CSRs blocked, ecall back up
        csr_op(CSR_W, `CSR_ADDR_MSTATUS, 32'h0);
        trap_op(CSR_MRET);
        csr_op(CSR_S, `CSR_ADDR_MSCRATCH, 32'h0);
        csr_op(CSR_W, `CSR_ADDR_MSCRATCH, next_rand());
        trap_op(CSR_ECALL);
        csr_op(CSR_S, `CSR_ADDR_MCAUSE, 32'h0);
        csr_op(CSR_S, `CSR_ADDR_MSCRATCH, 32'h0);

        // Timer interrupt, armed while mtip is still low
        csr_op(CSR_W, `CSR_ADDR_MTVEC, (next_rand() & ~32'h3) | 32'h1);
        set_timer(64'd100, '1);
        csr_op(CSR_W, `CSR_ADDR_MIE, 32'h80);
        csr_op(CSR_W, `CSR_ADDR_MSTATUS, 32'h1808);
        n = 0;
        while (!stall_may_irq && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!stall_may_irq) begin
            $display("Timeout: stall_may_irq never rose after MIE and MTIE were set");
            timeouts++;
        end
        base = m_mtvec & ~32'h3;
        pc   = next_rand() & ~32'h3;
        @(posedge clk);
        fetch_pc  <= pc;
        mtimecmp  <= 64'd50;
        irq_ready <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (resp.cmd != CSR_ECALL && n < 20);
        if (resp.cmd != CSR_ECALL) begin
            $display("Timeout: timer interrupt was not taken with irq_ready high");
            timeouts++;
        end else begin
            check_value("resp.trap_vector", base + 32'd28, resp.trap_vector);
        end
        @(posedge clk);
        irq_ready <= 1'b0;
        m_mpp    = m_mode;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
        m_mode   = 2'b11;
        m_mepc   = pc;
        m_mcause = `CSR_CAUSE_MTIMER;
        @(negedge clk);
        check_value("stall_may_irq", 32'(m_mie && m_mtie), 32'(stall_may_irq));
        csr_op(CSR_S, `CSR_ADDR_MEPC, 32'h0);
        csr_op(CSR_S, `CSR_ADDR_MCAUSE, 32'h0);
        csr_op(CSR_S, `CSR_ADDR_MSTATUS, 32'h0);
        csr_op(CSR_S, `CSR_ADDR_MIP, 32'h0);

        // Flushed write is a bubble
        send(CSR_W, `CSR_ADDR_MSCRATCH, next_rand(), 1'b1, got);
        check_value("resp.cmd", 32'(CSR_NONE), 32'(got.cmd));
        check_value("resp.rdata", 32'h0, got.rdata);
        csr_op(CSR_S, `CSR_ADDR_MSCRATCH, 32'h0);

        repeat (2) @(posedge clk);
        $display("Errors: checks=%0d timeouts=%0d assertions=%0d", errors, timeouts,
                 u_csr_unit.u_csr_unit_props.fail_count);
        if (errors + timeouts + u_csr_unit.u_csr_unit_props.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/csr_pkg.sv
design/csr_timer.sv
design/csr_trap_ctrl.sv
design/csr_regfile.sv
design/csr_unit.sv
verif/csr_unit_props.sv
verif/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - include_dirs:
      - design
    files:
      - design/csr_pkg.sv
      - design/csr_timer.sv
      - design/csr_trap_ctrl.sv
      - design/csr_regfile.sv
      - design/csr_unit.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/csr_unit_props.sv
      - verif/csr_unit_tb.sv
